/* source/ppu_pkg.sv */
`default_nettype none

package ppu_pkg;

    // dot and line numbers share one width
    typedef logic [8:0] coord_t;
    typedef logic [5:0] color_t;
    typedef logic [4:0] pal_idx_t;
    typedef logic [13:0] vaddr_t;

    // frame geometry, one dot per clk
    localparam coord_t DOTS_PER_LINE = 9'd341;
    localparam coord_t LINES_PER_FRAME = 9'd262;
    localparam coord_t VISIBLE_W = 9'd256;
    localparam coord_t VISIBLE_H = 9'd240;
    localparam coord_t VBLANK_LINE = 9'd241;
    localparam coord_t PRE_LINE = 9'd261;
    // status flag is set and cleared on the second dot of its line
    localparam coord_t FLAG_DOT = 9'd1;

    localparam int PAL_ENTRIES = 32;

    // upper address bits of the palette window at 0x3F00
    localparam logic [5:0] PAL_BASE_HI = 6'h3F;

    // cpu register selects, 3..5 reserved
    typedef enum logic [2:0] {
        REG_CTRL   = 3'd0,
        REG_MASK   = 3'd1,
        REG_STATUS = 3'd2,
        REG_ADDR   = 3'd6,
        REG_DATA   = 3'd7
    } reg_sel_t;

    // register bit positions
    localparam int CTRL_INC_BIT = 2;
    localparam int CTRL_NMI_BIT = 7;
    localparam int MASK_GREY_BIT = 0;
    localparam int STATUS_VBL_BIT = 7;

    // greyscale keeps only the luma bits of a color
    localparam color_t GREY_MASK = 6'h30;

endpackage

`default_nettype wire

/* source/ppu_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module ppu_timing (
    input  wire logic            clk,
    input  wire logic            rst_n,
    output ppu_pkg::coord_t      line,
    output logic                 vbl_set,
    output logic                 vbl_clr,
    output logic                 visible
);

    // vertical phase of the frame
    typedef enum logic [1:0] {
        PH_VISIBLE,
        PH_POST,
        PH_VBLANK,
        PH_PRE
    } phase_t;

    ppu_pkg::coord_t dot;
    phase_t          phase;
    phase_t          phase_next;
    logic            last_dot;

    assign last_dot = (dot == ppu_pkg::DOTS_PER_LINE - 9'd1);

    // dot and line counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dot  <= '0;
            line <= '0;
        end else if (last_dot) begin
            dot <= '0;
            if (line == ppu_pkg::LINES_PER_FRAME - 9'd1) begin
                line <= '0;
            end else begin
                line <= line + 9'd1;
            end
        end else begin
            dot <= dot + 9'd1;
        end
    end

    // phase moves only at the end of a line
    always_comb begin
        phase_next = phase;
        if (last_dot) begin
            case (phase)
                PH_VISIBLE: begin
                    if (line == ppu_pkg::VISIBLE_H - 9'd1) phase_next = PH_POST;
                end
                PH_POST: begin
                    if (line == ppu_pkg::VBLANK_LINE - 9'd1) phase_next = PH_VBLANK;
                end
                PH_VBLANK: begin
                    if (line == ppu_pkg::PRE_LINE - 9'd1) phase_next = PH_PRE;
                end
                PH_PRE: begin
                    phase_next = PH_VISIBLE;
                end
                default: phase_next = PH_VISIBLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= PH_VISIBLE;
        end else begin
            phase <= phase_next;
        end
    end

    // vblank only starts on its first line
    assign vbl_set = (phase == PH_VBLANK) && (line == ppu_pkg::VBLANK_LINE)
                     && (dot == ppu_pkg::FLAG_DOT);
    assign vbl_clr = (phase == PH_PRE) && (dot == ppu_pkg::FLAG_DOT);
    assign visible = (phase == PH_VISIBLE) && (dot < ppu_pkg::VISIBLE_W);

endmodule

`default_nettype wire

/* source/ppu_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module ppu_regs (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              reg_en,
    input  wire logic              reg_rw,
    input  wire ppu_pkg::reg_sel_t reg_sel,
    input  wire logic [7:0]        reg_data_in,
    input  wire logic              vbl_set,
    input  wire logic              vbl_clr,
    input  wire ppu_pkg::color_t   pal_rdata,
    output logic [7:0]             reg_data_out,
    output logic                   nmi_n,
    output logic                   grey,
    output logic                   pal_we,
    output ppu_pkg::pal_idx_t      pal_addr,
    output ppu_pkg::color_t        pal_wdata
);

    logic [7:0]      ctrl;
    logic [7:0]      mask;
    logic            vbl_flag;
    // low = next PPUADDR write is the high byte
    logic            addr_latch;
    ppu_pkg::vaddr_t vaddr;

    logic            wr_en;
    logic            rd_en;
    logic            in_window;
    ppu_pkg::vaddr_t vaddr_inc;
    logic            status_rd;

    assign wr_en = reg_en && reg_rw;
    assign rd_en = reg_en && !reg_rw;

    assign in_window = (vaddr[13:8] == ppu_pkg::PAL_BASE_HI);
    assign vaddr_inc = ctrl[ppu_pkg::CTRL_INC_BIT] ? 14'd32 : 14'd1;
    assign status_rd = rd_en && (reg_sel == ppu_pkg::REG_STATUS);

    // palette only sees writes inside the window
    assign pal_we    = wr_en && (reg_sel == ppu_pkg::REG_DATA) && in_window;
    assign pal_addr  = vaddr[4:0];
    assign pal_wdata = reg_data_in[5:0];

    assign grey  = mask[ppu_pkg::MASK_GREY_BIT];
    assign nmi_n = !(vbl_flag && ctrl[ppu_pkg::CTRL_NMI_BIT]);

    // a set on the same cycle as a status read wins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vbl_flag <= 1'b0;
        end else if (vbl_set) begin
            vbl_flag <= 1'b1;
        end else if (vbl_clr || status_rd) begin
            vbl_flag <= 1'b0;
        end
    end

    // register writes and address stepping
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl       <= '0;
            mask       <= '0;
            addr_latch <= 1'b0;
            vaddr      <= '0;
        end else if (wr_en) begin
            case (reg_sel)
                ppu_pkg::REG_CTRL: ctrl <= reg_data_in;
                ppu_pkg::REG_MASK: mask <= reg_data_in;
                ppu_pkg::REG_ADDR: begin
                    if (!addr_latch) begin
                        vaddr[13:8] <= reg_data_in[5:0];
                    end else begin
                        vaddr[7:0] <= reg_data_in;
                    end
                    addr_latch <= !addr_latch;
                end
                ppu_pkg::REG_DATA: vaddr <= vaddr + vaddr_inc;
                default: ;
            endcase
        end else if (rd_en) begin
            if (reg_sel == ppu_pkg::REG_STATUS) begin
                addr_latch <= 1'b0;
            end else if (reg_sel == ppu_pkg::REG_DATA) begin
                vaddr <= vaddr + vaddr_inc;
            end
        end
    end

    // read data holds until the next read strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_data_out <= '0;
        end else if (rd_en) begin
            case (reg_sel)
                ppu_pkg::REG_CTRL: reg_data_out <= ctrl;
                ppu_pkg::REG_MASK: reg_data_out <= mask;
                ppu_pkg::REG_STATUS: begin
                    reg_data_out <= '0;
                    reg_data_out[ppu_pkg::STATUS_VBL_BIT] <= vbl_flag;
                end
                // outside the palette window reads back as 0
                ppu_pkg::REG_DATA: reg_data_out <= in_window ? {2'b00, pal_rdata} : 8'h00;
                default: reg_data_out <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/palette_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module palette_ram (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              we,
    input  wire ppu_pkg::pal_idx_t addr,
    input  wire ppu_pkg::color_t   wdata,
    output ppu_pkg::color_t        rdata,
    output ppu_pkg::color_t        backdrop
);

    ppu_pkg::color_t   mem [ppu_pkg::PAL_ENTRIES];
    ppu_pkg::pal_idx_t idx;

    // 0x10/0x14/0x18/0x1C fold onto the background entries
    always_comb begin
        idx = addr;
        if (addr[4] && addr[1:0] == 2'b00) begin
            idx[4] = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ppu_pkg::PAL_ENTRIES; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[idx] <= wdata;
        end
    end

    assign rdata    = mem[idx];
    assign backdrop = mem[0];

endmodule

`default_nettype wire

/* source/pixel_out.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_out (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             visible,
    input  wire logic             grey,
    input  wire ppu_pkg::color_t  backdrop,
    output logic                  pixel_valid,
    output ppu_pkg::color_t       pixel_color
);

    ppu_pkg::color_t color_next;

    // greyscale drops the hue bits
    always_comb begin
        if (grey) begin
            color_next = backdrop & ppu_pkg::GREY_MASK;
        end else begin
            color_next = backdrop;
        end
    end

    // one cycle from a visible dot to the output
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pixel_valid <= 1'b0;
            pixel_color <= '0;
        end else begin
            pixel_valid <= visible;
            pixel_color <= color_next;
        end
    end

endmodule

`default_nettype wire

/* source/ppu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ppu_top (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              reg_en,
    input  wire logic              reg_rw,
    input  wire ppu_pkg::reg_sel_t reg_sel,
    input  wire logic [7:0]        reg_data_in,
    output logic [7:0]             reg_data_out,
    output logic                   nmi_n,
    output logic                   pixel_valid,
    output ppu_pkg::color_t        pixel_color
);

    logic              vbl_set;
    logic              vbl_clr;
    logic              visible;
    logic              grey;
    logic              pal_we;
    ppu_pkg::pal_idx_t pal_addr;
    ppu_pkg::color_t   pal_wdata;
    ppu_pkg::color_t   pal_rdata;
    ppu_pkg::color_t   backdrop;

    // line number is not needed outside the timing block
    ppu_timing u_timing (
        .clk     (clk),
        .rst_n   (rst_n),
        .line    (),
        .vbl_set (vbl_set),
        .vbl_clr (vbl_clr),
        .visible (visible)
    );

    ppu_regs u_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .reg_en       (reg_en),
        .reg_rw       (reg_rw),
        .reg_sel      (reg_sel),
        .reg_data_in  (reg_data_in),
        .vbl_set      (vbl_set),
        .vbl_clr      (vbl_clr),
        .pal_rdata    (pal_rdata),
        .reg_data_out (reg_data_out),
        .nmi_n        (nmi_n),
        .grey         (grey),
        .pal_we       (pal_we),
        .pal_addr     (pal_addr),
        .pal_wdata    (pal_wdata)
    );

    palette_ram u_palette (
        .clk      (clk),
        .rst_n    (rst_n),
        .we       (pal_we),
        .addr     (pal_addr),
        .wdata    (pal_wdata),
        .rdata    (pal_rdata),
        .backdrop (backdrop)
    );

    pixel_out u_pixel (
        .clk         (clk),
        .rst_n       (rst_n),
        .visible     (visible),
        .grey        (grey),
        .backdrop    (backdrop),
        .pixel_valid (pixel_valid),
        .pixel_color (pixel_color)
    );

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* verification/ppu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ppu_tb;

    localparam int FRAME_CYCLES = 341 * 262;
    localparam int VISIBLE_DOTS = 256 * 240;
    // one status poll is a strobe cycle and an idle cycle
    localparam int POLL_SLACK = 2;
    // about four frames plus the register traffic
    localparam int TIMEOUT_CYCLES = 400000;

    logic              clk;
    logic              rst_n;
    logic              reg_en;
    logic              reg_rw;
    ppu_pkg::reg_sel_t reg_sel;
    logic [7:0]        reg_data_in;
    logic [7:0]        reg_data_out;
    logic              nmi_n;
    logic              pixel_valid;
    ppu_pkg::color_t   pixel_color;

    int errors = 0;
    int checks = 0;
    int cycles = 0;
    // cycle of the last observed flag set or -1
    int last_vbl = -1;

    tb_clock u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ppu_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .reg_en       (reg_en),
        .reg_rw       (reg_rw),
        .reg_sel      (reg_sel),
        .reg_data_in  (reg_data_in),
        .reg_data_out (reg_data_out),
        .nmi_n        (nmi_n),
        .pixel_valid  (pixel_valid),
        .pixel_color  (pixel_color)
    );

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the cases did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input int got, input int expected);
        checks++;
        assert (got == expected) else begin
            errors++;
            $display("FAILED at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, expected);
        end
    endtask

    // a cases line must carry all of its fields
    task automatic check_fields(input logic [7:0] op, input int got, input int want);
        assert (got == want) else begin
            errors++;
            $display("a %s line of the cases file has %0d fields instead of %0d",
                     op, got, want);
        end
    endtask

    task automatic write_reg(input logic [7:0] sel, input logic [7:0] data);
        @(negedge clk);
        reg_en      = 1'b1;
        reg_rw      = 1'b1;
        reg_sel     = ppu_pkg::reg_sel_t'(sel[2:0]);
        reg_data_in = data;
        @(negedge clk);
        reg_en = 1'b0;
        reg_rw = 1'b0;
    endtask

    // data is taken one cycle after the strobe
    task automatic read_reg(input logic [7:0] sel, output logic [7:0] data);
        @(negedge clk);
        reg_en  = 1'b1;
        reg_rw  = 1'b0;
        reg_sel = ppu_pkg::reg_sel_t'(sel[2:0]);
        @(negedge clk);
        reg_en = 1'b0;
        data   = reg_data_out;
    endtask

    // poll status until the vblank bit shows, then check the frame length
    task automatic wait_vblank();
        logic [7:0] status;
        int         interval;
        status = 8'h00;
        while (!status[7]) begin
            read_reg(8'h02, status);
        end
        if (last_vbl >= 0) begin
            interval = cycles - last_vbl;
            checks++;
            assert (interval >= FRAME_CYCLES - POLL_SLACK
                    && interval <= FRAME_CYCLES + POLL_SLACK) else begin
                errors++;
                $display("FAILED at %0t: vblank interval = %0d, expected %0d",
                         $time, interval, FRAME_CYCLES);
            end
        end
        last_vbl = cycles;
    endtask

    task automatic count_frame(input logic [7:0] grey, input logic [7:0] color);
        logic [5:0] expected;
        int         valid_count;
        int         bad_pixels;
        // greyscale keeps bits 5:4 only
        expected    = grey[0] ? (color[5:0] & 6'h30) : color[5:0];
        valid_count = 0;
        bad_pixels  = 0;
        repeat (FRAME_CYCLES) begin
            @(negedge clk);
            if (pixel_valid) begin
                valid_count++;
                assert (pixel_color == expected) else begin
                    errors++;
                    if (bad_pixels == 0) begin
                        $display("FAILED at %0t: pixel_color = 0x%0h, expected 0x%0h",
                                 $time, pixel_color, expected);
                    end
                    bad_pixels++;
                end
            end
        end
        if (bad_pixels > 1) begin
            $display("pixel_color was wrong on %0d pixels of this frame", bad_pixels);
        end
        check_value("pixel_valid cycles", valid_count, VISIBLE_DOTS);
    endtask

    task automatic run_cases(input int fd);
        logic [7:0]       op;
        logic [7:0]       arg_a;
        logic [7:0]       arg_b;
        logic [7:0]       got;
        logic [8*128-1:0] rest;
        int               code;
        while ($fscanf(fd, "%s", op) == 1) begin
            case (op)
                "#": code = $fgets(rest, fd);
                "W": begin
                    code = $fscanf(fd, "%h %h", arg_a, arg_b);
                    check_fields(op, code, 2);
                    write_reg(arg_a, arg_b);
                end
                "R": begin
                    code = $fscanf(fd, "%h %h", arg_a, arg_b);
                    check_fields(op, code, 2);
                    read_reg(arg_a, got);
                    check_value("reg_data_out", int'(got), int'(arg_b));
                end
                "V": wait_vblank();
                "P": begin
                    code = $fscanf(fd, "%h %h", arg_a, arg_b);
                    check_fields(op, code, 2);
                    count_frame(arg_a, arg_b);
                end
                "N": begin
                    code = $fscanf(fd, "%h", arg_a);
                    check_fields(op, code, 1);
                    @(negedge clk);
                    check_value("nmi_n", int'(nmi_n), int'(arg_a));
                end
                default: begin
                    errors++;
                    $display("unknown command %s in the cases file", op);
                end
            endcase
        end
    endtask

    initial begin
        int fd;
        reg_en      = 1'b0;
        reg_rw      = 1'b0;
        reg_sel     = ppu_pkg::REG_CTRL;
        reg_data_in = 8'h00;

        @(posedge rst_n);
        // outputs still hold their reset values here
        check_value("nmi_n", int'(nmi_n), 1);
        check_value("pixel_valid", int'(pixel_valid), 0);
        check_value("reg_data_out", int'(reg_data_out), 0);

        fd = $fopen("verification/ppu_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open verification/ppu_cases.txt");
        end else begin
            run_cases(fd);
            $fclose(fd);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
source/ppu_pkg.sv
source/ppu_timing.sv
source/ppu_regs.sv
source/palette_ram.sv
source/pixel_out.sv
source/ppu_top.sv
verification/tb_clock.sv
verification/ppu_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds and runs the ppu testbench with verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -f build.f \
    --top-module ppu_tb -o ppu_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/ppu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0

/* verification/ppu_cases.txt */
# op reg data: W writes data, R reads and expects data (hex), V waits for vblank
# P grey color: one frame of backdrop pixels, N level: expected nmi_n
R 0 00
R 1 00
R 2 00
# palette, increment by 1, data masked to 6 bits
W 6 3F
W 6 00
W 7 21
W 7 15
W 7 3C
W 6 3F
W 6 00
R 7 21
R 7 15
R 7 3C
# outside the palette window
W 6 20
W 6 00
W 7 11
W 6 20
W 6 00
R 7 00
# increment by 32, 0x3F21 lands on entry 1
W 0 04
R 0 04
W 6 3F
W 6 01
W 7 0A
W 7 EB
W 0 00
W 6 3F
W 6 01
R 7 2B
# 0x3F10 mirrors 0x3F00, status read resets the address latch
W 6 3F
W 6 10
W 7 2A
W 6 3F
R 2 00
W 6 3F
W 6 00
R 7 2A
# vblank flag, frame length, nmi and pixel frames
V
R 2 00
V
W 0 80
P 0 2A
N 0
R 2 80
N 1
W 0 00
W 1 01
R 1 01
P 1 2A
N 1
R 2 80
